//--- logic/whack_a_mole_pkg.sv
package whack_a_mole_pkg;

    //////////////////////////////////////////////////
    // Board size and field widths
    //////////////////////////////////////////////////

    localparam int num_holes = 4;                   // Buttons and mole LEDs

    typedef logic [num_holes-1:0] hole_mask_t;      // One bit per hole
    typedef logic [28:0]          timer_t;          // Delay and window cycle count
    typedef logic [7:0]           score_t;          // Player score
    typedef logic [3:0]           lives_t;          // Remaining lives
    typedef logic [7:0]           lfsr_t;           // Hole generator state

    localparam lives_t start_lives = 4'd3;          // Lives given at game start

    //////////////////////////////////////////////////
    // Game FSM and round control
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE       = 3'b000,                        // Waiting for any press
        GAMEPLAY   = 3'b001,                        // Rounds running
        END_SCREEN = 3'b010                         // Final score shown
    } game_state_t;

    // One-cycle pulses from game control to the timing blocks
    typedef struct packed {
        logic start;                                // Arm delay for the next mole
        logic stop;                                 // Current round judged
    } round_ctrl_t;

    // Each threshold the score exceeds takes one step off the hammer window
    localparam score_t speed_thresholds [9] = '{
        8'd5,  8'd20, 8'd30,
        8'd40, 8'd50, 8'd60,
        8'd70, 8'd80, 8'd90
    };

endpackage

//--- logic/mole_scheduler.sv
`timescale 1ns/10ps

module mole_scheduler
    import whack_a_mole_pkg::*;
#(
    parameter int MOLE_DELAY = 100_000_000          // Cycles from round start to mole, min 2
) (
    input  logic        clk,
    input  logic        reset,
    input  round_ctrl_t round,
    output hole_mask_t  mole,
    output logic        mole_up
);

    localparam int sel_bits = $clog2(num_holes);    // LFSR bits used to pick a hole

    timer_t delay_cnt;                              // Nonzero while a round waits for its mole
    logic   delay_done;                             // Last delay cycle
    lfsr_t  lfsr;
    logic   lfsr_fb;

    //////////////////////////////////////////////////
    // Hole generator
    //////////////////////////////////////////////////

    // Maximal length taps x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    // Free running so the pick depends on when the player presses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= lfsr_t'(1);                     // Any nonzero seed
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};
        end
    end

    //////////////////////////////////////////////////
    // Round delay
    //////////////////////////////////////////////////

    assign delay_done = (delay_cnt == timer_t'(1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            delay_cnt <= '0;
        end else if (round.stop) begin
            delay_cnt <= '0;                        // Round over so drop any pending mole
        end else if (round.start) begin
            // The start cycle itself is the first delay cycle
            delay_cnt <= timer_t'(MOLE_DELAY - 1);
        end else if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Mole LEDs
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mole    <= '0;
            mole_up <= 1'b0;
        end else begin
            mole_up <= 1'b0;                        // Pulse by default low
            if (round.stop) begin
                mole <= '0;                         // Cleared on the judging edge
            end else if (delay_done) begin
                mole    <= hole_mask_t'(1) << lfsr[sel_bits-1:0];  // Exactly one hole
                mole_up <= 1'b1;                    // Opens the hammer window
            end
        end
    end

endmodule

//--- logic/hammer_window.sv
`timescale 1ns/10ps

module hammer_window
    import whack_a_mole_pkg::*;
#(
    parameter int HAMMER_WINDOW = 300_000_000,      // Window at level 0
    parameter int WINDOW_STEP   = 24_900_000        // Cut per level reached
) (
    input  logic        clk,
    input  logic        reset,
    input  round_ctrl_t round,
    input  logic        mole_up,
    input  score_t      score,
    output logic        expired
);

    logic [3:0] level;                              // Thresholds passed, 0 to 9
    timer_t     window_len;                         // Window for the current score
    timer_t     window_cnt;                         // Nonzero while the hammer may strike

    //////////////////////////////////////////////////
    // Difficulty
    //////////////////////////////////////////////////

    always_comb begin
        level = '0;
        for (int i = 0; i < $size(speed_thresholds); i++) begin
            if (score > speed_thresholds[i]) begin
                level = level + 1'b1;               // Strictly above the threshold
            end
        end
    end

    // Shorter window for every level
    assign window_len = timer_t'(HAMMER_WINDOW) - timer_t'(WINDOW_STEP * level);

    //////////////////////////////////////////////////
    // Window counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            window_cnt <= '0;
            expired    <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (round.stop) begin
                window_cnt <= '0;                   // Round judged so no window
            end else if (mole_up) begin
                // Score sampled here and held for the whole window
                window_cnt <= window_len - 1'b1;
            end else if (window_cnt == timer_t'(1)) begin
                window_cnt <= '0;
                expired    <= 1'b1;                 // Player ran out of time
            end else if (window_cnt != '0) begin
                window_cnt <= window_cnt - 1'b1;
            end
        end
    end

endmodule

//--- logic/game_control.sv
`timescale 1ns/10ps

module game_control
    import whack_a_mole_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  hole_mask_t  button,                     // Debounced levels
    input  hole_mask_t  mole,                       // Lit hole
    input  logic        expired,                    // Hammer window over
    output round_ctrl_t round,
    output score_t      score,
    output lives_t      lives,
    output game_state_t state
);

    hole_mask_t button_prev;                        // Buttons one cycle ago
    hole_mask_t press;                              // Rising edges seen this cycle
    logic       judging;                            // In play with a mole lit
    logic       hit;
    logic       wrong;
    logic       miss;
    logic       lose;                               // Wrong press or miss
    logic       judge_stop;
    logic       start_q;                            // Registered round start

    //////////////////////////////////////////////////
    // Button edges
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            button_prev <= '0;
        end else begin
            button_prev <= button;
        end
    end

    assign press = button & ~button_prev;           // Held buttons count once

    //////////////////////////////////////////////////
    // Judging
    //////////////////////////////////////////////////

    // Presses during the round delay are ignored
    assign judging = (state == GAMEPLAY) && (|mole);

    assign hit   = judging && (|(press & mole));
    assign wrong = judging && (|(press & ~mole)) && !hit;   // Hit wins on a double press
    assign miss  = judging && expired && !(|press);         // Late press still counts
    assign lose  = wrong || miss;

    // Ends the round on the same edge that updates score and lives
    assign judge_stop = hit || lose;

    assign round = '{start: start_q, stop: judge_stop};

    //////////////////////////////////////////////////
    // Game FSM with score and lives
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            score   <= '0;
            lives   <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;                        // Pulse by default low
            case (state)
                IDLE: begin
                    if (|press) begin               // Any button starts a game
                        state   <= GAMEPLAY;
                        score   <= '0;
                        lives   <= start_lives;
                        start_q <= 1'b1;            // First round
                    end
                end

                GAMEPLAY: begin
                    if (hit) begin
                        score   <= score + 1'b1;
                        start_q <= 1'b1;            // Next round
                    end else if (lose) begin
                        lives <= lives - 1'b1;
                        if (lives == lives_t'(1)) begin
                            state <= END_SCREEN;    // Last life gone
                        end else begin
                            start_q <= 1'b1;
                        end
                    end
                end

                END_SCREEN: begin
                    // Score stays on show until button 0
                    if (press[0]) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;                  // Unused encodings recover
                end
            endcase
        end
    end

endmodule

//--- logic/whack_a_mole.sv
`timescale 1ns/10ps

module whack_a_mole
    import whack_a_mole_pkg::*;
#(
    parameter int MOLE_DELAY    = 100_000_000,      // Round start to mole
    parameter int HAMMER_WINDOW = 300_000_000,      // Window at level 0
    parameter int WINDOW_STEP   = 24_900_000        // Cut per level
) (
    input  logic        clk,
    input  logic        reset,
    input  hole_mask_t  button,                     // Debounced buttons
    output hole_mask_t  mole,                       // Mole LEDs
    output score_t      score,
    output lives_t      lives,
    output game_state_t state
);

    round_ctrl_t round;                             // Start and stop pulses
    logic        mole_up;                           // Mole just lit
    logic        expired;                           // Window ran out

    //////////////////////////////////////////////////
    // Game control
    //////////////////////////////////////////////////

    game_control u_game_control (
        .clk     (clk),
        .reset   (reset),
        .button  (button),
        .mole    (mole),
        .expired (expired),
        .round   (round),
        .score   (score),
        .lives   (lives),
        .state   (state)
    );

    //////////////////////////////////////////////////
    // Round timing
    //////////////////////////////////////////////////

    mole_scheduler #(
        .MOLE_DELAY (MOLE_DELAY)
    ) u_mole_scheduler (
        .clk     (clk),
        .reset   (reset),
        .round   (round),
        .mole    (mole),
        .mole_up (mole_up)
    );

    hammer_window #(
        .HAMMER_WINDOW (HAMMER_WINDOW),
        .WINDOW_STEP   (WINDOW_STEP)
    ) u_hammer_window (
        .clk     (clk),
        .reset   (reset),
        .round   (round),
        .mole_up (mole_up),
        .score   (score),
        .expired (expired)
    );

endmodule

//--- testbench/tb_model.svh
// Event codes fed to the model
localparam int ev_none  = 0;                        // Press that the game ignores
localparam int ev_start = 1;                        // Game begins
localparam int ev_hit   = 2;                        // Lit hole struck
localparam int ev_lose  = 3;                        // Wrong press or miss
localparam int ev_back  = 4;                        // End screen left

//////////////////////////////////////////////////
// Difficulty
//////////////////////////////////////////////////

// Score levels from the game rules
function automatic int threshold_at(input int idx);
    case (idx)
        0:       return 5;
        default: return 10 * (idx + 1);             // 20, 30 up to 90
    endcase
endfunction

// Number of thresholds the score is strictly above
function automatic int level_model(input int score_v);
    int level;
    level = 0;
    for (int i = 0; i < 9; i++) begin
        if (score_v > threshold_at(i)) begin
            level++;
        end
    end
    return level;
endfunction

// Hammer window in cycles for a given score
function automatic int window_model(input int score_v, input int base_len, input int step);
    return base_len - step * level_model(score_v);
endfunction

//////////////////////////////////////////////////
// Score, lives and state after an event
//////////////////////////////////////////////////

function automatic int score_after(input int ev, input int score_v);
    if (ev == ev_start) return 0;                   // Fresh game
    if (ev == ev_hit) return score_v + 1;
    return score_v;                                 // Held on losses and end screen
endfunction

function automatic int lives_after(input int ev, input int lives_v);
    if (ev == ev_start) return 3;
    if (ev == ev_lose) return lives_v - 1;
    return lives_v;
endfunction

// Uses the lives from before the event
function automatic game_state_t state_after(input int ev, input int lives_v,
                                            input game_state_t state_v);
    case (ev)
        ev_start: return GAMEPLAY;
        ev_hit:   return GAMEPLAY;
        ev_lose:  return (lives_v == 1) ? END_SCREEN : GAMEPLAY;
        ev_back:  return IDLE;
        default:  return state_v;
    endcase
endfunction

//--- testbench/tb_whack_a_mole.sv
`timescale 1ns/10ps

module tb_whack_a_mole
    import whack_a_mole_pkg::*;
();

    localparam int mole_delay  = 20;                // Short timing for simulation
    localparam int window_base = 60;
    localparam int window_step = 8;
    localparam int wait_limit  = 400;               // Edges before a wait gives up

    logic        clk;
    logic        reset;
    hole_mask_t  button;
    hole_mask_t  mole;
    score_t      score;
    lives_t      lives;
    game_state_t state;

    int          errors;
    int          test_errors;                       // Error count when the test began
    int          tests_run;
    int          model_score;                       // Expected values
    int          model_lives;
    game_state_t model_state;
    logic        check_pending;                     // Outputs due for comparison

    `include "tb_model.svh"

    whack_a_mole #(
        .MOLE_DELAY    (mole_delay),
        .HAMMER_WINDOW (window_base),
        .WINDOW_STEP   (window_step)
    ) uut (
        .clk    (clk),
        .reset  (reset),
        .button (button),
        .mole   (mole),
        .score  (score),
        .lives  (lives),
        .state  (state)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                           // 10 ns period

    //////////////////////////////////////////////////
    // Output compare, mid cycle where outputs are stable
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (check_pending) begin
            if (score !== score_t'(model_score)) begin
                $display("Mismatch at %0t: score %0d, expected %0d", $time, score, model_score);
                errors++;
            end
            if (lives !== lives_t'(model_lives)) begin
                $display("Mismatch at %0t: lives %0d, expected %0d", $time, lives, model_lives);
                errors++;
            end
            if (state !== model_state) begin
                $display("Mismatch at %0t: state %0d, expected %0d", $time, state, model_state);
                errors++;
            end
            if (mole !== '0) begin                  // Every judged event clears the mole
                $display("Mismatch at %0t: mole %b, expected 0000", $time, mole);
                errors++;
            end
            check_pending = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic int holes_lit(input hole_mask_t mask);
        int n;
        n = 0;
        for (int i = 0; i < num_holes; i++) begin
            n += mask[i];
        end
        return n;
    endfunction

    function automatic int hole_index(input hole_mask_t mask);
        int idx;
        idx = 0;
        for (int i = 0; i < num_holes; i++) begin
            if (mask[i]) idx = i;
        end
        return idx;
    endfunction

    // Random hole other than the lit one
    function automatic int wrong_hole(input hole_mask_t mask);
        return (hole_index(mask) + 1 + $urandom % (num_holes - 1)) % num_holes;
    endfunction

    // Model step then flag the outputs for the compare process
    task automatic post_event(input int ev);
        model_state = state_after(ev, model_lives, model_state);
        model_score = score_after(ev, model_score);
        model_lives = lives_after(ev, model_lives);
        check_pending = 1'b1;
    endtask

    // Returns just after the judging edge
    task automatic press_button(input int idx);
        button[idx] = 1'b1;
        @(posedge clk);
        #1;
    endtask

    // Held for a second edge, then one low edge so the next press is new
    task automatic release_buttons();
        @(posedge clk);
        #1;
        button = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_mole(input int edges_done);
        int count;
        count = edges_done;                         // Edges already past the judging edge
        while (mole == '0 && count < wait_limit) begin
            @(posedge clk);
            #1;
            count++;
        end
        if (mole == '0) begin
            $display("Timeout waiting for a mole to light at %0t", $time);
            $display("Regression failed");
            $finish;
        end else begin
            if (count != mole_delay) begin
                $display("Mismatch at %0t: mole after %0d cycles, expected %0d",
                         $time, count, mole_delay);
                errors++;
            end
            if (holes_lit(mole) != 1) begin
                $display("Mismatch at %0t: %0d holes lit, expected 1", $time, holes_lit(mole));
                errors++;
            end
        end
    endtask

    // No press, so the window must run out and cost a life
    task automatic wait_miss();
        int     count;
        int     expect_len;
        lives_t lives_before;
        // The edge after the expired pulse judges the miss
        expect_len = window_model(model_score, window_base, window_step) + 1;
        lives_before = lives;
        count = 0;
        while (lives === lives_before && count < wait_limit) begin
            @(posedge clk);
            #1;
            count++;
            if (lives === lives_before && mole == '0) begin
                $display("Mismatch at %0t: mole cleared before the window ran out", $time);
                errors++;
            end
        end
        if (lives === lives_before) begin
            $display("Timeout waiting for the hammer window to expire at %0t", $time);
            $display("Regression failed");
            $finish;
        end else begin
            if (count != expect_len) begin
                $display("Mismatch at %0t: miss judged after %0d cycles, expected %0d",
                         $time, count, expect_len);
                errors++;
            end
            post_event(ev_lose);
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = 0;
        while (check_pending && n < 4) begin        // Let the last compare run
            @(posedge clk);
            #1;
            n++;
        end
        if (check_pending) begin
            $display("Timeout waiting for the output compare in test %s", name);
            $display("Regression failed");
            $finish;
        end else begin
            tests_run++;
            if (errors == test_errors) $display("Test %s: ok", name);
            else $display("Test %s: FAIL with %0d errors", name, errors - test_errors);
            test_errors = errors;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h646a0358));
        reset         = 1'b1;
        button        = '0;
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        check_pending = 1'b0;
        model_score   = 0;
        model_lives   = 0;
        model_state   = IDLE;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        check_pending = 1'b1;                       // Reset values
        end_test("reset");

        press_button($urandom % num_holes);         // Any button starts
        post_event(ev_start);
        release_buttons();
        wait_mole(2);
        end_test("start");

        repeat (7) begin
            press_button(hole_index(mole));
            post_event(ev_hit);
            release_buttons();
            wait_mole(2);
        end
        end_test("hit");

        press_button(wrong_hole(mole));
        post_event(ev_lose);
        release_buttons();
        wait_mole(2);
        end_test("wrong press");

        wait_miss();                                // Score 7 gives level 1
        wait_mole(0);
        end_test("miss");

        press_button(wrong_hole(mole));             // Last life lost
        post_event(ev_lose);
        release_buttons();
        for (int b = 1; b < num_holes; b++) begin
            press_button(b);                        // Ignored on the end screen
            post_event(ev_none);
            release_buttons();
        end
        press_button(0);
        post_event(ev_back);
        release_buttons();
        press_button($urandom % num_holes);         // New game
        post_event(ev_start);
        release_buttons();
        wait_mole(2);
        end_test("game over");

        $display("Tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+testbench
logic/whack_a_mole_pkg.sv
logic/mole_scheduler.sv
logic/hammer_window.sv
logic/game_control.sv
logic/whack_a_mole.sv
testbench/tb_whack_a_mole.sv
